//--- Bender.yml
package:
  name: security_alert_unit

sources:
  - alert_pkg.sv
  - alert_cfg_regs.sv
  - fault_classifier.sv
  - nmi_tracker.sv
  - alert_aggregator.sv
  - security_alert_unit.sv
  - target: test
    files:
      - tb_security_alert_unit.sv

//--- alert_aggregator.sv
`timescale 1ns/10ps

module alert_aggregator (
  input  logic                  clk_i,
  input  logic                  rst,
  input  alert_pkg::lockup_t    lfsr_lockup,
  input  logic                  fault_hit,
  input  logic                  nmi_taken,
  input  alert_pkg::alert_src_t src_enable,
  output logic                  alert_minor,
  output alert_pkg::alert_src_t cause_set
);

  alert_pkg::alert_src_t raw_events;
  alert_pkg::alert_src_t gated_events;
  alert_pkg::alert_src_t events_q;

  // Raw event vector, one bit per source
  // Any of the three LFSRs locking up counts as a single lockup event
  always_comb begin
    raw_events                        = '0;
    raw_events[alert_pkg::SRC_LOCKUP] = |lfsr_lockup;
    raw_events[alert_pkg::SRC_FAULT]  = fault_hit;
    raw_events[alert_pkg::SRC_NMI]    = nmi_taken;
  end

  // Masked sources give neither an alert nor a cause bit
  assign gated_events = raw_events & src_enable;

  // Events are registered so the alert is a clean one-cycle pulse
  always_ff @(posedge clk_i) begin
    if (rst) begin
      events_q <= '0;
    end else begin
      events_q <= gated_events;
    end
  end

  // Several sources in the same cycle still give one pulse
  assign alert_minor = |events_q;

  // The cause register records each source separately
  assign cause_set = events_q;

endmodule

//--- alert_cfg_regs.sv
`timescale 1ns/10ps

module alert_cfg_regs (
  input  logic                 clk_i,
  input  logic                 rst,
  input  logic                 cfg_req_valid,
  input  alert_pkg::cfg_req_t  cfg_req,
  input  alert_pkg::alert_src_t cause_set,
  output logic                 cfg_ack,
  output alert_pkg::cfg_data_t cfg_rdata,
  output alert_pkg::alert_src_t src_enable
);

  alert_pkg::cfg_state_e  state_q;
  alert_pkg::cfg_state_e  state_next;
  alert_pkg::alert_src_t  mask_q;
  alert_pkg::alert_src_t  cause_q;
  alert_pkg::alert_src_t  cause_clr;
  alert_pkg::cfg_data_t   rdata_q;
  logic                   access;
  logic                   wr_mask;
  logic                   wr_cause;

  // The access itself happens on the edge that leaves CFG_ACK
  assign access   = (state_q == alert_pkg::CFG_ACK);
  assign wr_mask  = access && cfg_req.write && (cfg_req.addr == alert_pkg::CFG_ADDR_MASK);
  assign wr_cause = access && cfg_req.write && (cfg_req.addr == alert_pkg::CFG_ADDR_CAUSE);

  // Write-one-to-clear mask for the sticky cause bits
  assign cause_clr = wr_cause ? cfg_req.wdata : '0;

  // Handshake sequencing
  // A request is only picked up in idle, and ack is held until the master lets go
  always_comb begin
    state_next = state_q;
    case (state_q)
      alert_pkg::CFG_IDLE: begin
        if (cfg_req_valid) begin
          state_next = alert_pkg::CFG_ACK;
        end
      end
      alert_pkg::CFG_ACK: begin
        state_next = alert_pkg::CFG_WAIT_LOW;
      end
      alert_pkg::CFG_WAIT_LOW: begin
        if (!cfg_req_valid) begin
          state_next = alert_pkg::CFG_IDLE;
        end
      end
      default: begin
        state_next = alert_pkg::CFG_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      state_q <= alert_pkg::CFG_IDLE;
      mask_q  <= '1;
      cause_q <= '0;
    end else begin
      state_q <= state_next;
      if (wr_mask) begin
        mask_q <= cfg_req.wdata;
      end
      // A new event in the same cycle survives the clear
      cause_q <= (cause_q & ~cause_clr) | cause_set;
    end
  end

  // Read data is captured with the access and stays put while ack is high
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= (cfg_req.addr == alert_pkg::CFG_ADDR_MASK) ? mask_q : cause_q;
    end
  end

  assign cfg_ack    = (state_q == alert_pkg::CFG_WAIT_LOW);
  assign cfg_rdata  = rdata_q;
  assign src_enable = mask_q;

endmodule

//--- alert_input.txt
# lock valid trap exc cause rvalid err integ debug step stepie op addr data alert pending
# op before the cycle is 0 none, 1 write, 2 read checked against the model; all values decimal
0 0 0 0 0   0 0 0   0 0 0   0 0 0   0 0
1 0 0 0 0   0 0 0   0 0 0   0 0 0   1 0
0 0 0 0 0   0 0 0   0 0 0   0 0 0   0 0
6 0 0 0 0   0 0 0   0 0 0   0 0 0   1 0
0 0 0 0 0   0 0 0   0 0 0   2 1 0   0 0
0 0 0 0 0   0 0 0   0 0 0   1 1 7   0 0
0 1 1 1 1   0 0 0   0 0 0   0 0 0   1 0
0 1 1 1 2   0 0 0   0 0 0   0 0 0   1 0
0 1 1 1 5   0 0 0   0 0 0   0 0 0   1 0
0 1 1 1 7   0 0 0   0 0 0   0 0 0   1 0
0 1 1 1 24  0 0 0   0 0 0   0 0 0   1 0
0 1 1 1 3   0 0 0   0 0 0   0 0 0   0 0
0 1 1 0 1   0 0 0   0 0 0   0 0 0   0 0
0 1 0 1 2   0 0 0   0 0 0   0 0 0   0 0
0 0 1 1 5   0 0 0   0 0 0   0 0 0   0 0
0 0 0 0 0   1 1 0   1 0 0   0 0 0   0 1
0 0 0 0 0   1 1 0   1 0 0   0 0 0   0 1
0 0 0 0 0   0 0 0   0 1 0   0 0 0   0 1
0 0 0 0 0   0 0 0   0 1 1   0 0 0   1 0
0 0 0 0 0   0 0 0   0 0 0   0 0 0   0 0
0 0 0 0 0   1 1 1   0 0 0   0 0 0   0 0
0 0 0 0 0   0 1 0   0 0 0   0 0 0   0 0
0 0 0 0 0   1 1 0   0 0 0   0 0 0   0 1
0 0 0 0 0   0 0 0   0 0 0   0 0 0   1 0
0 0 0 0 0   0 0 0   0 0 0   2 1 0   0 0
7 0 0 0 0   0 0 0   0 0 0   1 0 6   0 0
0 1 1 1 2   0 0 0   0 0 0   1 1 7   1 0
1 1 1 1 7   0 0 0   0 0 0   2 0 0   1 0
0 0 0 0 0   1 1 0   0 0 0   1 0 3   0 1
0 0 0 0 0   0 0 0   0 0 0   0 0 0   0 0
0 1 1 1 1   0 0 0   0 0 0   1 0 5   0 0
0 0 0 0 0   0 0 0   0 0 0   2 1 0   0 0
0 0 0 0 0   0 0 0   0 0 0   1 0 7   0 0
0 0 0 0 0   0 0 0   0 0 0   1 1 7   0 0

//--- alert_pkg.sv
package alert_pkg;

  // Exception cause code as carried on the retirement interface
  typedef logic [5:0] exc_cause_t;

  // One lockup flag per random-number LFSR in the core
  typedef logic [2:0] lockup_t;

  // One bit per minor alert source, indexed by the SRC_* positions
  typedef logic [2:0] alert_src_t;

  // Configuration port address and data
  typedef logic [0:0] cfg_addr_t;
  typedef logic [2:0] cfg_data_t;

  // Trap causes that count as a fault and raise a minor alert
  localparam exc_cause_t CAUSE_INSTR_ACCESS_FAULT = 6'd1;
  localparam exc_cause_t CAUSE_ILLEGAL_INSTR      = 6'd2;
  localparam exc_cause_t CAUSE_LOAD_ACCESS_FAULT  = 6'd5;
  localparam exc_cause_t CAUSE_STORE_ACCESS_FAULT = 6'd7;
  localparam exc_cause_t CAUSE_INSTR_BUS_FAULT    = 6'd24;

  // Bit positions inside an alert source vector
  localparam int unsigned SRC_LOCKUP = 0;
  localparam int unsigned SRC_FAULT  = 1;
  localparam int unsigned SRC_NMI    = 2;

  // Register map of the configuration block
  localparam cfg_addr_t CFG_ADDR_MASK  = 1'b0;
  localparam cfg_addr_t CFG_ADDR_CAUSE = 1'b1;

  // Retired instruction as seen on the trace port
  typedef struct packed {
    logic       valid;
    logic       trap;
    logic       exception;
    exc_cause_t cause;
  } retire_t;

  // Data bus response together with the integrity flag of its request
  typedef struct packed {
    logic rvalid;
    logic err;
    logic had_integrity;
  } dbus_rsp_t;

  // Debug state of the core that decides whether an NMI can be taken
  typedef struct packed {
    logic debug_mode;
    logic step;
    logic stepie;
  } core_mode_t;

  // Request payload of the configuration port
  typedef struct packed {
    logic      write;
    cfg_addr_t addr;
    cfg_data_t wdata;
  } cfg_req_t;

  typedef enum logic [0:0] {
    NMI_IDLE    = 1'b0,
    NMI_PENDING = 1'b1
  } nmi_state_e;

  typedef enum logic [1:0] {
    CFG_IDLE     = 2'd0,
    CFG_ACK      = 2'd1,
    CFG_WAIT_LOW = 2'd2
  } cfg_state_e;

endpackage

//--- fault_classifier.sv
`timescale 1ns/10ps

module fault_classifier (
  input  alert_pkg::retire_t retire,
  output logic               fault_hit
);

  logic cause_is_fault;
  logic trapped;

  // Only a retired instruction that really trapped on an exception is looked at
  assign trapped = retire.valid && retire.trap && retire.exception;

  // Fault cause set
  // Adding a cause here is all it takes to extend the alert coverage
  always_comb begin
    case (retire.cause)
      alert_pkg::CAUSE_INSTR_ACCESS_FAULT: begin
        cause_is_fault = 1'b1;
      end
      alert_pkg::CAUSE_ILLEGAL_INSTR: begin
        cause_is_fault = 1'b1;
      end
      alert_pkg::CAUSE_LOAD_ACCESS_FAULT: begin
        cause_is_fault = 1'b1;
      end
      alert_pkg::CAUSE_STORE_ACCESS_FAULT: begin
        cause_is_fault = 1'b1;
      end
      alert_pkg::CAUSE_INSTR_BUS_FAULT: begin
        cause_is_fault = 1'b1;
      end
      default: begin
        cause_is_fault = 1'b0;
      end
    endcase
  end

  // Interrupts and plain retirements never reach this point
  assign fault_hit = trapped && cause_is_fault;

endmodule

//--- nmi_tracker.sv
`timescale 1ns/10ps

module nmi_tracker (
  input  logic                  clk_i,
  input  logic                  rst,
  input  alert_pkg::dbus_rsp_t  dbus_rsp,
  input  alert_pkg::core_mode_t core_mode,
  output logic                  pending_nmi,
  output logic                  nmi_taken
);

  alert_pkg::nmi_state_e state_q;
  alert_pkg::nmi_state_e state_next;
  logic                  bus_err;
  logic                  interruptible;

  // Errors on requests with integrity checking go to the major alert path instead
  assign bus_err = dbus_rsp.rvalid && dbus_rsp.err && !dbus_rsp.had_integrity;

  // Debug mode blocks the NMI, and so does single stepping with interrupts masked
  assign interruptible = !core_mode.debug_mode && (!core_mode.step || core_mode.stepie);

  always_comb begin
    state_next = state_q;
    nmi_taken  = 1'b0;
    case (state_q)
      alert_pkg::NMI_IDLE: begin
        if (bus_err) begin
          state_next = alert_pkg::NMI_PENDING;
        end
      end
      alert_pkg::NMI_PENDING: begin
        // Further errors while pending fold into the same NMI
        if (interruptible) begin
          nmi_taken  = 1'b1;
          state_next = alert_pkg::NMI_IDLE;
        end
      end
      default: begin
        state_next = alert_pkg::NMI_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      state_q <= alert_pkg::NMI_IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  assign pending_nmi = (state_q == alert_pkg::NMI_PENDING);

endmodule

//--- project.f
alert_pkg.sv
alert_cfg_regs.sv
fault_classifier.sv
nmi_tracker.sv
alert_aggregator.sv
security_alert_unit.sv
tb_security_alert_unit.sv

//--- security_alert_unit.sv
`timescale 1ns/10ps

module security_alert_unit (
  input  logic                  clk_i,
  input  logic                  rst,
  input  alert_pkg::lockup_t    lfsr_lockup,
  input  alert_pkg::retire_t    retire,
  input  alert_pkg::dbus_rsp_t  dbus_rsp,
  input  alert_pkg::core_mode_t core_mode,
  input  logic                  cfg_req_valid,
  input  alert_pkg::cfg_req_t   cfg_req,
  output logic                  cfg_ack,
  output alert_pkg::cfg_data_t  cfg_rdata,
  output logic                  alert_minor,
  output logic                  pending_nmi
);

  logic                  fault_hit;
  logic                  nmi_taken;
  alert_pkg::alert_src_t src_enable;
  alert_pkg::alert_src_t cause_set;

  // Enable mask and sticky cause register behind the req/ack port
  alert_cfg_regs cfg_regs_i (
    .clk_i         (clk_i),
    .rst           (rst),
    .cfg_req_valid (cfg_req_valid),
    .cfg_req       (cfg_req),
    .cause_set     (cause_set),
    .cfg_ack       (cfg_ack),
    .cfg_rdata     (cfg_rdata),
    .src_enable    (src_enable)
  );

  // Decides whether the retiring instruction trapped on a fault
  fault_classifier fault_classifier_i (
    .retire    (retire),
    .fault_hit (fault_hit)
  );

  // Holds the NMI from an unchecked bus error until the core can take it
  nmi_tracker nmi_tracker_i (
    .clk_i       (clk_i),
    .rst         (rst),
    .dbus_rsp    (dbus_rsp),
    .core_mode   (core_mode),
    .pending_nmi (pending_nmi),
    .nmi_taken   (nmi_taken)
  );

  // Merges all sources into the minor alert
  alert_aggregator alert_aggregator_i (
    .clk_i       (clk_i),
    .rst         (rst),
    .lfsr_lockup (lfsr_lockup),
    .fault_hit   (fault_hit),
    .nmi_taken   (nmi_taken),
    .src_enable  (src_enable),
    .alert_minor (alert_minor),
    .cause_set   (cause_set)
  );

endmodule

//--- tb_security_alert_unit.sv
`timescale 1ns/10ps

module tb_security_alert_unit;

  localparam int CLK_PERIOD  = 20;
  localparam int RAND_CYCLES = 40;

  // The clock starts low before any process runs, so time zero has no falling edge
  logic                  clk_i = 1'b0;
  logic                  rst;
  alert_pkg::lockup_t    lfsr_lockup;
  alert_pkg::retire_t    retire;
  alert_pkg::dbus_rsp_t  dbus_rsp;
  alert_pkg::core_mode_t core_mode;
  logic                  cfg_req_valid;
  alert_pkg::cfg_req_t   cfg_req;
  logic                  cfg_ack;
  alert_pkg::cfg_data_t  cfg_rdata;
  logic                  alert_minor;
  logic                  pending_nmi;

  // Fields of the current vector in the column order of the input file
  int f_lock;
  int f_valid, f_trap, f_exc, f_cause;
  int f_rvalid, f_err, f_integ;
  int f_dbg, f_step, f_stepie;
  int f_op, f_addr, f_data;
  int f_alert, f_pend;

  // Reference model state that mirrors the mask, the cause register and the NMI
  logic [2:0] model_mask;
  logic [2:0] model_cause;
  logic       model_pending;
  int         budget_cycles = 0;

  security_alert_unit dut_i (
    .clk_i         (clk_i),
    .rst           (rst),
    .lfsr_lockup   (lfsr_lockup),
    .retire        (retire),
    .dbus_rsp      (dbus_rsp),
    .core_mode     (core_mode),
    .cfg_req_valid (cfg_req_valid),
    .cfg_req       (cfg_req),
    .cfg_ack       (cfg_ack),
    .cfg_rdata     (cfg_rdata),
    .alert_minor   (alert_minor),
    .pending_nmi   (pending_nmi)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // The five fault causes are instr access, illegal instr, load access, store/AMO access
  // and instr bus
  function automatic bit is_fault_cause(input int cause);
    return (cause == 1) || (cause == 2) || (cause == 5) || (cause == 7) || (cause == 24);
  endfunction

  function automatic int pick_fault_cause(input int k);
    case (k % 5)
      0: return 1;
      1: return 2;
      2: return 5;
      3: return 7;
      default: return 24;
    endcase
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Four-phase access that starts and finishes on a falling edge
  task automatic cfg_access(input bit wr, input int addr, input int wdata,
                            output logic [2:0] rdata);
    int edges;
    cfg_req.write = wr;
    cfg_req.addr  = addr[0];
    cfg_req.wdata = wdata[2:0];
    cfg_req_valid = 1'b1;
    edges = 0;
    do begin
      @(negedge clk_i);
      edges++;
    end while (!cfg_ack && edges < 8);
    assert (cfg_ack === 1'b1) else fail_run("Configuration ack never rose after the request");
    assert (edges == 2) else fail_run($sformatf(
      "FAILED at %0t ns: ack rose after %0d edges, expected 2", $time, edges));
    rdata = cfg_rdata;
    cfg_req_valid = 1'b0;
    edges = 0;
    do begin
      @(negedge clk_i);
      edges++;
    end while (cfg_ack && edges < 8);
    assert (cfg_ack === 1'b0)
      else fail_run("Configuration ack never fell after the request dropped");
    assert (edges == 1) else fail_run($sformatf(
      "FAILED at %0t ns: ack fell after %0d edges, expected 1", $time, edges));
  endtask

  // One vector runs an optional config access and then one cycle of stimulus and its check
  task automatic run_cycle(input int idx, input bit from_file);
    logic [2:0] events;
    logic [2:0] rdata;
    logic [2:0] exp_rd;
    logic       interruptible;
    if (f_op != 0) begin
      // Event inputs rest while the port is busy and core_mode keeps its value
      lfsr_lockup = '0;
      retire      = '0;
      dbus_rsp    = '0;
      cfg_access(f_op == 1, f_addr, f_data, rdata);
      if (f_op == 1 && f_addr == 0) begin
        model_mask = f_data[2:0];
      end else if (f_op == 1) begin
        model_cause = model_cause & ~f_data[2:0];
      end else begin
        exp_rd = (f_addr == 0) ? model_mask : model_cause;
        assert (rdata === exp_rd) else fail_run($sformatf(
          "FAILED at %0t ns: vector %0d read %b from address %0d, expected %b",
          $time, idx, rdata, f_addr, exp_rd));
      end
    end
    lfsr_lockup          = f_lock[2:0];
    retire.valid         = f_valid[0];
    retire.trap          = f_trap[0];
    retire.exception     = f_exc[0];
    retire.cause         = f_cause[5:0];
    dbus_rsp.rvalid      = f_rvalid[0];
    dbus_rsp.err         = f_err[0];
    dbus_rsp.had_integrity = f_integ[0];
    core_mode.debug_mode = f_dbg[0];
    core_mode.step       = f_step[0];
    core_mode.stepie     = f_stepie[0];
    // The NMI can be taken outside debug mode, unless stepping with interrupts masked
    interruptible = !f_dbg[0] && (!f_step[0] || f_stepie[0]);
    events[0] = (f_lock != 0);
    events[1] = f_valid[0] && f_trap[0] && f_exc[0] && is_fault_cause(f_cause);
    events[2] = model_pending && interruptible;
    events = events & model_mask;
    if (model_pending) begin
      model_pending = !interruptible;
    end else begin
      model_pending = f_rvalid[0] && f_err[0] && !f_integ[0];
    end
    model_cause = model_cause | events;
    @(negedge clk_i);
    if (from_file) begin
      assert (f_alert[0] == |events && f_pend[0] == model_pending) else fail_run($sformatf(
        "Vector %0d in alert_input.txt contradicts the alert rules", idx));
    end
    assert (alert_minor === |events) else fail_run($sformatf(
      "FAILED at %0t ns: vector %0d alert_minor is %b, expected %b",
      $time, idx, alert_minor, |events));
    assert (pending_nmi === model_pending) else fail_run($sformatf(
      "FAILED at %0t ns: vector %0d pending_nmi is %b, expected %b",
      $time, idx, pending_nmi, model_pending));
  endtask

  // Watchdog sized from the vector count once the file has been scanned
  initial begin
    wait (budget_cycles > 0);
    #(budget_cycles * CLK_PERIOD);
    fail_run("Timeout: the test did not finish within the expected number of cycles");
  end

  initial begin
    int          fd;
    int          n;
    int          lines;
    int          idx;
    string       line;
    logic [31:0] lcg_state;
    rst           = 1'b1;
    lfsr_lockup   = '0;
    retire        = '0;
    dbus_rsp      = '0;
    core_mode     = '0;
    cfg_req_valid = 1'b0;
    cfg_req       = '0;
    model_mask    = 3'b111;
    model_cause   = 3'b000;
    model_pending = 1'b0;
    // The first pass only counts the vectors
    fd = $fopen("alert_input.txt", "r");
    assert (fd != 0) else fail_run("Could not open alert_input.txt for reading");
    lines = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        lines++;
      end
    end
    $fclose(fd);
    // A vector with a config access takes up to four cycles
    budget_cycles = 4 * lines + RAND_CYCLES + 50;
    repeat (2) @(negedge clk_i);
    assert (alert_minor === 1'b0 && pending_nmi === 1'b0 && cfg_ack === 1'b0)
      else fail_run($sformatf("FAILED at %0t ns: outputs are not low after reset", $time));
    rst = 1'b0;
    fd = $fopen("alert_input.txt", "r");
    idx = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        idx++;
        n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    f_lock, f_valid, f_trap, f_exc, f_cause, f_rvalid, f_err, f_integ,
                    f_dbg, f_step, f_stepie, f_op, f_addr, f_data, f_alert, f_pend);
        assert (n == 16)
          else fail_run($sformatf("Vector %0d in alert_input.txt is malformed", idx));
        run_cycle(idx, 1'b1);
      end
    end
    $fclose(fd);
    // Random retirements where half the causes are drawn from the fault set
    f_lock   = 0;
    f_rvalid = 0;
    f_err    = 0;
    f_integ  = 0;
    f_dbg    = 0;
    f_step   = 0;
    f_stepie = 0;
    f_op     = 0;
    lcg_state = 32'h65d7;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      lcg_state = lcg_next(lcg_state);
      f_valid = (lcg_state[31:30] != 2'b00);
      f_trap  = (lcg_state[29:28] != 2'b00);
      f_exc   = (lcg_state[27:26] != 2'b00);
      if (lcg_state[24]) begin
        f_cause = pick_fault_cause(lcg_state[18:16]);
      end else begin
        f_cause = lcg_state[21:16];
      end
      run_cycle(idx + i + 1, 1'b0);
    end
    // Cause register must hold exactly the faults of the random phase
    f_valid = 0;
    f_trap  = 0;
    f_exc   = 0;
    f_cause = 0;
    f_op    = 2;
    f_addr  = 1;
    run_cycle(idx + RAND_CYCLES + 1, 1'b0);
    $display("Simulation passed");
    $finish;
  end

endmodule
